// File: mips_cpu_bus.f
+incdir+include
src/mips_pkg.sv
src/mips_sequencer.sv
src/mips_decoder.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_pc_unit.sv
src/mips_cpu_bus.sv
sim/avalon_mem_model.sv
sim/tb_mips_cpu_bus.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f mips_cpu_bus.f --top-module tb_mips_cpu_bus -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
else
  exit 1
fi

// File: sim/tb_mips_cpu_bus.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module tb_mips_cpu_bus;

  localparam int CYCLE_LIMIT = 6 * 40 * 16;   // tests x instructions x worst cycles
  localparam logic [5:0] OP_J = 6'h02, OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI = 6'h0A, OP_ANDI = 6'h0C, OP_ORI = 6'h0D, OP_XORI = 6'h0E;
  localparam logic [5:0] OP_LUI = 6'h0F, OP_LW = 6'h23, OP_SW = 6'h2B;
  localparam logic [5:0] FN_SLL = 6'h00, FN_SRL = 6'h02, FN_JR = 6'h08, FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26;
  localparam logic [5:0] FN_SLT = 6'h2A;
  localparam mips_pkg::word_t RV = `MIPS_RESET_VECTOR;

  logic clk, reset, active, read, write, waitrequest;
  logic clear, load_en, wait_en;
  logic [3:0] byteenable;
  logic [31:0] xfer_count;
  mips_pkg::word_t register_v0, address, writedata, readdata;
  mips_pkg::word_t load_addr, load_data, last_wr_addr, last_wr_data;
  mips_pkg::word_t prog [$];                  // program image with word 0 at the reset vector
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  mips_cpu_bus u_mips_cpu_bus (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .address(address), .write(write), .read(read), .waitrequest(waitrequest),
    .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
  );

  avalon_mem_model u_mem (
    .clk(clk), .clear(clear), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .wait_en(wait_en),
    .address(address), .read(read), .write(write), .writedata(writedata),
    .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest),
    .last_wr_addr(last_wr_addr), .last_wr_data(last_wr_data), .xfer_count(xfer_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // caps the run when the cpu never halts
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: cpu did not halt within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  // the memory aliases, so every transfer has to stay inside the loaded 1 KB window
  always @(negedge clk) begin
    if ((read === 1'b1 || write === 1'b1) && (address[31:10] !== RV[31:10])) begin
      errors++;
      $display("bus access at %h falls outside the program memory window", address);
    end
  end

  function automatic mips_pkg::word_t enc_r(input logic [5:0] fn, input mips_pkg::reg_idx_t rs,
      input mips_pkg::reg_idx_t rt, input mips_pkg::reg_idx_t rd, input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input mips_pkg::reg_idx_t rs,
      input mips_pkg::reg_idx_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic mips_pkg::word_t enc_j(input mips_pkg::word_t target);
    return {OP_J, target[27:2]};              // upper bits come from pc+4
  endfunction

  task automatic check_word(input string test, input string what,
                            input mips_pkg::word_t exp, input mips_pkg::word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string test, input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: %s expected %b actual %b", test, what, exp, act);
    end
  endtask

  // the cpu sits halted or in reset while the image goes in
  task automatic load_program(input logic waits);
    @(posedge clk);
    clear   <= 1'b1;
    wait_en <= waits;
    @(posedge clk);
    clear <= 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      load_en   <= 1'b1;
      load_addr <= RV + 32'(4 * i);
      load_data <= prog[i];
      @(posedge clk);
    end
    load_en <= 1'b0;
  endtask

  // four cycle reset, bus start check, then wait for the halt
  task automatic run_program(input string test);
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_bit(test, "read in reset", 1'b0, read);
      check_bit(test, "write in reset", 1'b0, write);
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit(test, "read after reset", 1'b0, read);
    check_bit(test, "write after reset", 1'b0, write);
    check_bit(test, "active after reset", 1'b1, active);
    while (read !== 1'b1) @(negedge clk);
    check_word(test, "first fetch address", RV, address);
    while (active === 1'b1) @(negedge clk);    // halt drops active
  endtask

  task automatic finish_prog();
    prog.push_back(enc_r(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));  // jr $0 halts
    prog.push_back(32'h0000_0000);                           // delay slot nop
  endtask

  task automatic test_alu();
    mips_pkg::word_t r8, r9, r10, r11, r12, r13, r14, r15, r16, r17, r18, r19, r20, r21, r22;
    r8  = 32'h0000_1234;
    r9  = 32'hFFFF_FFFD;                       // -3 sign extended
    r10 = r8 + r9;
    r11 = r8 - r9;
    r12 = r10 & r11;
    r13 = r12 | r9;
    r14 = r13 ^ r10;
    r15 = r14 & 32'h0000_F0F0;                 // logical immediates zero extend
    r16 = r15 | 32'h0000_8001;
    r17 = r16 ^ 32'h0000_FFFF;
    r18 = 32'hABCD_0000;
    r19 = r17 << 4;
    r20 = r18 >> 8;
    r21 = ($signed(r9) < $signed(r8)) ? 32'd1 : 32'd0;
    r22 = ($signed(r8) < -1) ? 32'd1 : 32'd0;
    prog.delete();
    prog.push_back(enc_i(OP_ADDIU, 0, 8, 16'h1234));
    prog.push_back(enc_i(OP_ADDIU, 0, 9, 16'hFFFD));
    prog.push_back(enc_r(FN_ADDU, 8, 9, 10, 0));
    prog.push_back(enc_r(FN_SUBU, 8, 9, 11, 0));
    prog.push_back(enc_r(FN_AND, 10, 11, 12, 0));
    prog.push_back(enc_r(FN_OR, 12, 9, 13, 0));
    prog.push_back(enc_r(FN_XOR, 13, 10, 14, 0));
    prog.push_back(enc_i(OP_ANDI, 14, 15, 16'hF0F0));
    prog.push_back(enc_i(OP_ORI, 15, 16, 16'h8001));
    prog.push_back(enc_i(OP_XORI, 16, 17, 16'hFFFF));
    prog.push_back(enc_i(OP_LUI, 0, 18, 16'hABCD));
    prog.push_back(enc_r(FN_SLL, 0, 17, 19, 4));
    prog.push_back(enc_r(FN_SRL, 0, 18, 20, 8));
    prog.push_back(enc_r(FN_SLT, 9, 8, 21, 0));
    prog.push_back(enc_i(OP_SLTI, 8, 22, 16'hFFFF));
    prog.push_back(enc_r(FN_ADDU, 19, 20, 2, 0));
    prog.push_back(enc_r(FN_ADDU, 2, 14, 2, 0));
    prog.push_back(enc_r(FN_ADDU, 2, 21, 2, 0));
    prog.push_back(enc_r(FN_ADDU, 2, 22, 2, 0));
    prog.push_back(enc_i(OP_ADDIU, 0, 0, 16'h0005));   // $zero must stay zero
    prog.push_back(enc_r(FN_ADDU, 2, 0, 2, 0));
    finish_prog();
    load_program(1'b0);
    run_program("alu");
    check_word("alu", "v0", r19 + r20 + r14 + r21 + r22, register_v0);
  endtask

  task automatic test_load_store(input string test, input logic waits);
    mips_pkg::word_t data;
    data = 32'h1357_9BDF;
    prog.delete();
    prog.push_back(enc_i(OP_LUI, 0, 8, RV[31:16]));
    prog.push_back(enc_i(OP_ORI, 8, 8, 16'h0200));     // data area base
    prog.push_back(enc_i(OP_LUI, 0, 9, data[31:16]));
    prog.push_back(enc_i(OP_ORI, 9, 9, data[15:0]));
    prog.push_back(enc_i(OP_SW, 8, 9, 16'h0006));      // unaligned offset that the cpu word aligns
    prog.push_back(enc_i(OP_LW, 8, 10, 16'h0004));
    prog.push_back(enc_r(FN_ADDU, 10, 0, 2, 0));
    finish_prog();
    load_program(waits);
    run_program(test);
    check_word(test, "write address", RV + 32'h0000_0204, last_wr_addr);
    check_word(test, "write data", data, last_wr_data);
    check_word(test, "v0", data, register_v0);
  endtask

  task automatic test_branches();
    prog.delete();
    prog.push_back(enc_i(OP_ADDIU, 0, 8, 16'd5));      // 0
    prog.push_back(enc_i(OP_ADDIU, 0, 9, 16'd5));
    prog.push_back(enc_i(OP_ADDIU, 0, 2, 16'd0));
    prog.push_back(enc_i(OP_BEQ, 8, 9, 16'd3));        // 3 taken to 7
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0001));     // slot
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0002));
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0004));
    prog.push_back(enc_i(OP_BNE, 8, 9, 16'd2));        // 7 not taken
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0008));
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0010));
    prog.push_back(enc_i(OP_BNE, 8, 0, 16'd2));        // 10 taken to 13
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0020));
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0040));
    prog.push_back(enc_i(OP_BEQ, 8, 0, 16'd2));        // 13 not taken
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0080));
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0100));
    prog.push_back(enc_j(RV + 32'd76));                // 16 jumps to 19
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0200));
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0400));
    prog.push_back(enc_i(OP_ORI, 2, 2, 16'h0800));
    finish_prog();
    load_program(1'b0);
    run_program("branch");
    // slots and fall-through paths set their bits while skipped words leave theirs clear
    check_word("branch", "v0 signature",
               32'h0001 | 32'h0008 | 32'h0010 | 32'h0020 | 32'h0080 | 32'h0100 |
               32'h0200 | 32'h0800, register_v0);
  endtask

  task automatic test_halt();
    logic [31:0] count_at_halt;
    prog.delete();
    prog.push_back(enc_i(OP_ADDIU, 0, 2, 16'd1));
    prog.push_back(enc_r(FN_JR, 0, 0, 0, 0));
    prog.push_back(enc_i(OP_ADDIU, 2, 2, 16'd2));      // delay slot still runs
    prog.push_back(enc_i(OP_ADDIU, 2, 2, 16'd4));
    load_program(1'b0);
    run_program("halt");
    check_word("halt", "v0", 32'd3, register_v0);
    count_at_halt = xfer_count;
    repeat (12) begin
      @(negedge clk);
      check_bit("halt", "read while halted", 1'b0, read);
      check_bit("halt", "write while halted", 1'b0, write);
      check_bit("halt", "active while halted", 1'b0, active);
    end
    check_word("halt", "transfers after halt", count_at_halt, xfer_count);
  endtask

  initial begin
    reset     = 1'b1;
    clear     = 1'b0;
    load_en   = 1'b0;
    wait_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    test_alu();
    test_load_store("load_store", 1'b0);
    test_branches();
    test_halt();
    test_load_store("load_store_waits", 1'b1);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim/avalon_mem_model.sv
`timescale 1ns/1ps

module avalon_mem_model (
  input  logic            clk,
  input  logic            clear,         // empties memory, reseeds the lfsr
  input  logic            load_en,       // program loader port
  input  mips_pkg::word_t load_addr,
  input  mips_pkg::word_t load_data,
  input  logic            wait_en,       // random wait states on
  input  mips_pkg::word_t address,
  input  logic            read,
  input  logic            write,
  input  mips_pkg::word_t writedata,
  input  logic [3:0]      byteenable,
  output mips_pkg::word_t readdata,
  output logic            waitrequest,
  output mips_pkg::word_t last_wr_addr,  // last completed bus write
  output mips_pkg::word_t last_wr_data,
  output logic [31:0]     xfer_count     // completed transfers
);

  mips_pkg::word_t mem [256];            // 1 KB window, aliased over the address space
  logic [1:0]      wait_left;            // wait states still owed to this transfer
  logic [15:0]     lfsr;
  logic [7:0]      idx;

  // x^16 + x^14 + x^13 + x^11, shifts left, new bit enters at bit 0
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  assign idx         = address[9:2];     // word addressed
  assign readdata    = mem[idx];
  assign waitrequest = (read || write) && (wait_left != 2'd0);

  always @(posedge clk) begin : bus_proc
    logic [15:0] s1;
    logic [15:0] s2;
    if (clear) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= '0;                    // all zero decodes as sll $0 (nop)
      end
      wait_left    <= 2'd0;
      lfsr         <= 16'd85;
      xfer_count   <= '0;
      last_wr_addr <= '0;
      last_wr_data <= '0;
    end else if (load_en) begin
      mem[load_addr[9:2]] <= load_data;
    end else if (read || write) begin
      if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;   // stall one more cycle
      end else begin
        if (write && (byteenable == 4'hF)) begin
          mem[idx]     <= writedata;
          last_wr_addr <= address;
          last_wr_data <= writedata;
        end
        xfer_count <= xfer_count + 32'd1;
        if (wait_en) begin
          s1 = lfsr_step(lfsr);          // one step per bit taken
          s2 = lfsr_step(s1);
          wait_left <= {s1[0], s2[0]};   // 0..3 waits for the next transfer
          lfsr      <= s2;
        end
      end
    end
  end

endmodule

// File: src/mips_cpu_bus.sv
`timescale 1ns/1ps

module mips_cpu_bus (
  input  logic            clk,
  input  logic            reset,
  output logic            active,
  output mips_pkg::word_t register_v0,

  // avalon master
  output mips_pkg::word_t address,
  output logic            write,
  output logic            read,
  input  logic            waitrequest,
  output mips_pkg::word_t writedata,
  output logic [3:0]      byteenable,
  input  mips_pkg::word_t readdata
);

  mips_pkg::word_t    instr;          // latched at fetch
  mips_pkg::word_t    load_data;      // latched in mem access
  mips_pkg::word_t    pc;
  mips_pkg::word_t    rs_data, rt_data;
  mips_pkg::word_t    alu_result, imm_ext;
  mips_pkg::word_t    reg_wdata;
  mips_pkg::reg_idx_t wr_idx;
  mips_pkg::alu_op_t  alu_op;
  mips_pkg::reg_dst_t reg_dst;
  logic exec_en;
  logic alu_src_imm, imm_zero_ext;
  logic reg_write, is_load, is_store;
  logic branch_eq, branch_ne, jump, jump_reg;

  // destination is rd for r-type, rt otherwise
  assign wr_idx    = (reg_dst == mips_pkg::REG_DST_RD) ? instr[15:11] : instr[20:16];
  assign reg_wdata = is_load ? load_data : alu_result;  // lw returns memory word

  mips_sequencer u_sequencer (
    .clk(clk), .reset(reset),
    .pc(pc), .mem_addr(alu_result), .store_data(rt_data),  // sw stores rt
    .is_load(is_load), .is_store(is_store),
    .waitrequest(waitrequest), .readdata(readdata),
    .address(address), .writedata(writedata),
    .read(read), .write(write), .byteenable(byteenable),
    .instr(instr), .load_data(load_data),
    .exec_en(exec_en), .active(active)
  );

  mips_decoder u_decoder (
    .instr(instr),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
    .reg_dst(reg_dst), .reg_write(reg_write),
    .is_load(is_load), .is_store(is_store),
    .branch_eq(branch_eq), .branch_ne(branch_ne),
    .jump(jump), .jump_reg(jump_reg)
  );

  mips_pc_unit u_pc_unit (
    .clk(clk), .reset(reset), .exec_en(exec_en),
    .branch_eq(branch_eq), .branch_ne(branch_ne), .jump(jump), .jump_reg(jump_reg),
    .rs_data(rs_data), .rt_data(rt_data), .imm_ext(imm_ext),
    .jump_index(instr[25:0]),       // j target index
    .pc(pc)
  );

  mips_regfile u_regfile (
    .clk(clk), .reset(reset), .exec_en(exec_en), .reg_write(reg_write),
    .rs(instr[25:21]), .rt(instr[20:16]), .rd(wr_idx),
    .wdata(reg_wdata),
    .rs_data(rs_data), .rt_data(rt_data), .register_v0(register_v0)
  );

  mips_alu u_alu (
    .alu_op(alu_op), .rs_data(rs_data), .rt_data(rt_data),
    .imm16(instr[15:0]), .shamt(instr[10:6]),
    .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
    .result(alu_result), .imm_ext(imm_ext)
  );

endmodule

// File: src/mips_pc_unit.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_pc_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            exec_en,
  input  logic            branch_eq,
  input  logic            branch_ne,
  input  logic            jump,
  input  logic            jump_reg,
  input  mips_pkg::word_t rs_data,
  input  mips_pkg::word_t rt_data,
  input  mips_pkg::word_t imm_ext,      // sign extended offset
  input  logic [25:0]     jump_index,
  output mips_pkg::word_t pc
);

  mips_pkg::word_t pc_plus4;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  mips_pkg::word_t xfer_target;   // target of the current instruction
  mips_pkg::word_t target_hold;   // waits out the delay slot
  logic            cond_met;
  logic            taken;
  logic            delay;         // current instruction sits in a delay slot

  // pc still points at the executing instruction during exec
  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};  // same 256MB region

  assign cond_met = (branch_eq && (rs_data == rt_data)) ||
                    (branch_ne && (rs_data != rt_data));
  assign taken    = cond_met || jump || jump_reg;

  always_comb begin
    if (jump_reg) begin
      xfer_target = rs_data;          // jr target may be the halt address
    end else if (jump) begin
      xfer_target = jump_target;
    end else begin
      xfer_target = branch_target;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= `MIPS_RESET_VECTOR;
      delay <= 1'b0;
    end else if (exec_en) begin
      pc    <= delay ? target_hold : pc_plus4;  // redirect after the slot
      delay <= taken;
    end
  end

  // remember the target of a taken branch or jump
  always_ff @(posedge clk) begin
    if (exec_en && taken) target_hold <= xfer_target;
  end

endmodule

// File: src/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
  input  mips_pkg::alu_op_t  alu_op,
  input  mips_pkg::word_t    rs_data,
  input  mips_pkg::word_t    rt_data,
  input  logic [15:0]        imm16,
  input  mips_pkg::reg_idx_t shamt,
  input  logic               alu_src_imm,
  input  logic               imm_zero_ext,
  output mips_pkg::word_t    result,
  output mips_pkg::word_t    imm_ext    // also feeds the branch offset
);

  mips_pkg::word_t op_b;

  // andi/ori/xori zero extend, everything else sign extends
  assign imm_ext = imm_zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
  assign op_b    = alu_src_imm ? imm_ext : rt_data;

  always_comb begin
    case (alu_op)
      mips_pkg::ALU_ADD:    result = rs_data + op_b;   // no overflow trap
      mips_pkg::ALU_SUB:    result = rs_data - op_b;
      mips_pkg::ALU_AND:    result = rs_data & op_b;
      mips_pkg::ALU_OR:     result = rs_data | op_b;
      mips_pkg::ALU_XOR:    result = rs_data ^ op_b;
      mips_pkg::ALU_SLT: begin
        result = '0;
        result[0] = $signed(rs_data) < $signed(op_b);
      end
      mips_pkg::ALU_SLL:    result = op_b << shamt;    // shifts act on rt
      mips_pkg::ALU_SRL:    result = op_b >> shamt;    // logical, zero fill
      mips_pkg::ALU_LUI:    result = {op_b[15:0], 16'h0000};
      mips_pkg::ALU_PASS_B: result = op_b;
      default:              result = op_b;
    endcase
  end

endmodule

// File: src/mips_regfile.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_regfile (
  input  logic               clk,
  input  logic               reset,
  input  logic               exec_en,
  input  logic               reg_write,
  input  mips_pkg::reg_idx_t rs,
  input  mips_pkg::reg_idx_t rt,
  input  mips_pkg::reg_idx_t rd,        // write destination
  input  mips_pkg::word_t    wdata,
  output mips_pkg::word_t    rs_data,
  output mips_pkg::word_t    rt_data,
  output mips_pkg::word_t    register_v0
);

  mips_pkg::word_t regs [`MIPS_REG_COUNT];

  // combinational read ports
  assign rs_data     = regs[rs];
  assign rt_data     = regs[rt];
  assign register_v0 = regs[2];     // $v0

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (exec_en && reg_write && (rd != '0)) begin
      regs[rd] <= wdata;            // $zero stays zero
    end
  end

endmodule

// File: src/mips_decoder.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_decoder (
  input  mips_pkg::word_t    instr,
  output mips_pkg::alu_op_t  alu_op,
  output logic               alu_src_imm,    // operand b from immediate
  output logic               imm_zero_ext,   // logical immediates
  output mips_pkg::reg_dst_t reg_dst,
  output logic               reg_write,
  output logic               is_load,
  output logic               is_store,
  output logic               branch_eq,
  output logic               branch_ne,
  output logic               jump,
  output logic               jump_reg
);

  mips_pkg::opcode_t opcode;
  mips_pkg::funct_t  funct;

  assign opcode = mips_pkg::opcode_t'(instr[`MIPS_OP_HI:`MIPS_OP_LO]);
  assign funct  = mips_pkg::funct_t'(instr[`MIPS_FUNCT_HI:`MIPS_FUNCT_LO]);

  always_comb begin
    // anything not matched below falls through as a no-op
    alu_op       = mips_pkg::ALU_PASS_B;
    alu_src_imm  = 1'b0;
    imm_zero_ext = 1'b0;
    reg_dst      = mips_pkg::REG_DST_RT;
    reg_write    = 1'b0;
    is_load      = 1'b0;
    is_store     = 1'b0;
    branch_eq    = 1'b0;
    branch_ne    = 1'b0;
    jump         = 1'b0;
    jump_reg     = 1'b0;

    case (opcode)
      mips_pkg::OP_RTYPE: begin
        reg_dst   = mips_pkg::REG_DST_RD;
        reg_write = 1'b1;
        case (funct)
          mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
          mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
          mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;   // also the canonical nop
          mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
          mips_pkg::FN_JR: begin
            reg_write = 1'b0;
            jump_reg  = 1'b1;
          end
          default: reg_write = 1'b0;
        endcase
      end
      mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_LUI,
      mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        case (opcode)
          mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
          mips_pkg::OP_SLTI:  alu_op = mips_pkg::ALU_SLT;   // signed compare, sign ext
          mips_pkg::OP_LUI:   alu_op = mips_pkg::ALU_LUI;
          mips_pkg::OP_ANDI:  alu_op = mips_pkg::ALU_AND;
          mips_pkg::OP_ORI:   alu_op = mips_pkg::ALU_OR;
          default:            alu_op = mips_pkg::ALU_XOR;
        endcase
        imm_zero_ext = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI) ||
                       (opcode == mips_pkg::OP_XORI);
      end
      mips_pkg::OP_LW: begin
        alu_op      = mips_pkg::ALU_ADD;  // base + offset
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        is_load     = 1'b1;
      end
      mips_pkg::OP_SW: begin
        alu_op      = mips_pkg::ALU_ADD;
        alu_src_imm = 1'b1;
        is_store    = 1'b1;
      end
      mips_pkg::OP_BEQ: branch_eq = 1'b1;
      mips_pkg::OP_BNE: branch_ne = 1'b1;
      mips_pkg::OP_J:   jump      = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: src/mips_sequencer.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_sequencer (
  input  logic            clk,
  input  logic            reset,
  input  mips_pkg::word_t pc,
  input  mips_pkg::word_t mem_addr,     // alu effective address
  input  mips_pkg::word_t store_data,
  input  logic            is_load,
  input  logic            is_store,
  input  logic            waitrequest,
  input  mips_pkg::word_t readdata,
  output mips_pkg::word_t address,
  output mips_pkg::word_t writedata,
  output logic            read,
  output logic            write,
  output logic [3:0]      byteenable,
  output mips_pkg::word_t instr,
  output mips_pkg::word_t load_data,
  output logic            exec_en,
  output logic            active
);

  mips_pkg::cpu_state_t state;
  logic start_pending;  // bus stays idle in the first cycle out of reset
  logic at_halt;
  logic fetch_req;
  logic data_req;

  assign at_halt   = (pc == `MIPS_HALT_ADDR);
  assign fetch_req = (state == mips_pkg::FETCH) && !start_pending && !at_halt;
  assign data_req  = (state == mips_pkg::MEM_ACCESS);

  // pc during fetch, word aligned data address during mem access
  assign address    = data_req ? {mem_addr[`MIPS_WORD_W-1:2], 2'b00} : pc;
  assign read       = fetch_req | (data_req & is_load);
  assign write      = data_req & is_store;   // never together with read
  assign writedata  = store_data;            // rt is stable until exec
  assign byteenable = `MIPS_BYTEEN_ALL;
  assign exec_en    = (state == mips_pkg::EXEC);

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= mips_pkg::FETCH;
      start_pending <= 1'b1;
      active        <= 1'b1;
    end else begin
      case (state)
        mips_pkg::FETCH: begin
          if (start_pending) begin
            start_pending <= 1'b0;
          end else if (at_halt) begin     // jumped to address zero
            state  <= mips_pkg::HALTED;
            active <= 1'b0;
          end else if (!waitrequest) begin
            state <= mips_pkg::DECODE;
          end
        end
        mips_pkg::DECODE:
          state <= (is_load || is_store) ? mips_pkg::MEM_ACCESS : mips_pkg::EXEC;
        mips_pkg::MEM_ACCESS:
          if (!waitrequest) state <= mips_pkg::EXEC;  // hold under back-pressure
        mips_pkg::EXEC:   state <= mips_pkg::FETCH;
        mips_pkg::HALTED: state <= mips_pkg::HALTED;  // only reset leaves
        default:          state <= mips_pkg::FETCH;
      endcase
    end
  end

  // instruction and data registers
  always_ff @(posedge clk) begin
    if (fetch_req && !waitrequest) instr <= readdata;
    if (data_req && is_load && !waitrequest) load_data <= readdata;
  end

endmodule

// File: src/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

  typedef logic [`MIPS_WORD_W-1:0] word_t;               // data, address, instruction
  typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] reg_idx_t; // register number

  // instruction sequencing
  typedef enum logic [2:0] {
    FETCH,        // instruction read at pc
    DECODE,       // one cycle, operands settle
    MEM_ACCESS,   // lw / sw data transfer
    EXEC,         // register write and pc update
    HALTED        // parked until reset
  } cpu_state_t;

  // kept primary opcodes
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0A,
    OP_ANDI  = 6'h0C,
    OP_ORI   = 6'h0D,
    OP_XORI  = 6'h0E,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B
  } opcode_t;

  // kept r-type function codes
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI, ALU_PASS_B
  } alu_op_t;

  typedef enum logic {
    REG_DST_RT,   // i-type and loads write rt
    REG_DST_RD    // r-type writes rd
  } reg_dst_t;

endpackage

// File: include/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath sizing
`define MIPS_WORD_W     32          // data, address and instruction width
`define MIPS_REG_COUNT  32          // general purpose registers

// fetch addresses
`define MIPS_RESET_VECTOR 32'hBFC0_0000  // boot rom entry
`define MIPS_HALT_ADDR    32'h0000_0000  // fetch from here stops the cpu

// only full-word transfers on the avalon port
`define MIPS_BYTEEN_ALL 4'b1111

// instruction field positions
`define MIPS_OP_HI    31            // opcode msb
`define MIPS_OP_LO    26            // opcode lsb
`define MIPS_FUNCT_HI 5             // r-type function msb
`define MIPS_FUNCT_LO 0             // r-type function lsb

`endif
